/* hdl/axi_pkg.sv */
package axi_pkg;

  // channel widths for the M0 read port
  localparam int unsigned axi_id_bits   = 4;
  localparam int unsigned axi_addr_bits = 32;
  localparam int unsigned axi_data_bits = 32;
  localparam int unsigned axi_len_bits  = 4;
  localparam int unsigned axi_size_bits = 3;

  // burst type, only incrementing is issued
  localparam logic [1:0] axi_burst_incr = 2'b01;

  // size code is log2 of bytes per beat
  // 3'b010 means a full 32-bit word
  localparam logic [axi_size_bits-1:0] axi_size_4b = 3'b010;

  // read response codes
  // okay is normal completion
  localparam logic [1:0] axi_resp_okay = 2'b00;
  // slave error, reported back to the core as a fetch error
  localparam logic [1:0] axi_resp_slverr = 2'b10;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

  // opcodes live in the top nibble of every instruction
  // gaps are reserved and decode as no-ops
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_xor  = 4'd3,
    op_addi = 4'd8,
    op_halt = 4'd15
  } opcode_t;

  // index into the 8-entry register file
  typedef logic [2:0] reg_idx_t;

  // register form
  // rd = rs1 op rs2, low bits ignored
  typedef struct packed {
    opcode_t     opcode;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [18:0] unused;
  } r_form_t;

  // immediate form
  // rd = rs1 + sign-extended imm
  typedef struct packed {
    opcode_t            opcode;
    reg_idx_t           rd;
    reg_idx_t           rs1;
    logic signed [21:0] imm;
  } i_form_t;

  // one fetched word, two views
  // opcode, rd and rs1 sit at the same bits in both forms
  typedef union packed {
    r_form_t r_fmt;
    i_form_t i_fmt;
  } inst_t;

endpackage

/* hdl/fetch_axi_master.sv */
module fetch_axi_master (
  input  logic                               clk,
  input  logic                               rst,
  // core side
  input  logic                               fetch_req,
  input  logic [axi_pkg::axi_addr_bits-1:0]  fetch_addr,
  output logic                               fetch_done,
  output isa_pkg::inst_t                     fetch_data,
  output logic                               fetch_err,
  // AR channel
  output logic [axi_pkg::axi_id_bits-1:0]    arid,
  output logic [axi_pkg::axi_addr_bits-1:0]  araddr,
  output logic [axi_pkg::axi_len_bits-1:0]   arlen,
  output logic [axi_pkg::axi_size_bits-1:0]  arsize,
  output logic [1:0]                         arburst,
  output logic                               arvalid,
  input  logic                               arready,
  // R channel
  input  logic [axi_pkg::axi_id_bits-1:0]    rid,
  input  logic [axi_pkg::axi_data_bits-1:0]  rdata,
  input  logic [1:0]                         rresp,
  input  logic                               rlast,
  input  logic                               rvalid,
  output logic                               rready
);

  // fetches always go out as master 0, one beat
  localparam logic [axi_pkg::axi_id_bits-1:0]  id_m0      = '0;
  localparam logic [axi_pkg::axi_len_bits-1:0] len_single = '0;

  // one-hot state bit positions
  localparam int st_idle_bit = 0;
  localparam int st_addr_bit = 1;
  localparam int st_data_bit = 2;
  localparam int st_done_bit = 3;

  localparam logic [3:0] st_idle = 4'b0001 << st_idle_bit;
  localparam logic [3:0] st_addr = 4'b0001 << st_addr_bit;
  localparam logic [3:0] st_data = 4'b0001 << st_data_bit;
  localparam logic [3:0] st_done = 4'b0001 << st_done_bit;

  logic [3:0]     state;
  logic [3:0]     next_state;
  logic           ar_fire;
  logic           r_fire;
  isa_pkg::inst_t data_q;
  logic           err_q;

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    unique case (1'b1)
      // request seen, address phase starts next cycle
      state[st_idle_bit]: if (fetch_req) next_state = st_addr;
      // hold AR until the slave takes it
      state[st_addr_bit]: if (ar_fire) next_state = st_data;
      // single beat, so rlast closes the burst
      state[st_data_bit]: if (r_fire && rlast) next_state = st_done;
      state[st_done_bit]: next_state = st_idle;
      default:            next_state = st_idle;
    endcase
  end

  // word taken on the beat itself
  always_ff @(posedge clk) begin
    if (r_fire) begin
      data_q <= rdata;
    end
  end

  // any non-okay response or a stray id counts as a bus error
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      err_q <= 1'b0;
    end else if (r_fire) begin
      err_q <= (rresp != axi_pkg::axi_resp_okay) || (rid != id_m0);
    end
  end

  // fixed AR attributes
  assign arid    = id_m0;
  assign arlen   = len_single;
  assign arsize  = axi_pkg::axi_size_4b;
  assign arburst = axi_pkg::axi_burst_incr;

  // address only presented while in addr
  assign arvalid = state[st_addr_bit];
  assign araddr  = state[st_addr_bit] ? fetch_addr : '0;
  assign rready  = state[st_data_bit];

  // back to the core
  assign fetch_done = state[st_done_bit];
  assign fetch_data = data_q;
  assign fetch_err  = err_q;

endmodule

/* hdl/reg_file.sv */
module reg_file (
  input  logic              clk,
  input  logic              rst,
  // read ports
  input  isa_pkg::reg_idx_t rs1,
  input  isa_pkg::reg_idx_t rs2,
  output logic [31:0]       rd1,
  output logic [31:0]       rd2,
  // write port
  input  logic              we,
  input  isa_pkg::reg_idx_t wd_idx,
  input  logic [31:0]       wd
);

  // r0 has no storage
  logic [31:0] regs [1:7];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wd_idx != '0)) begin
      // writes to r0 are dropped
      regs[wd_idx] <= wd;
    end
  end

  // asynchronous reads
  // r0 is hardwired to zero
  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/inst_exec.sv */
module inst_exec (
  input  isa_pkg::inst_t    inst,
  input  logic [31:0]       op_a,
  input  logic [31:0]       op_b,
  output logic [31:0]       result,
  output isa_pkg::reg_idx_t dest,
  output logic              writes,
  output logic              is_halt
);

  isa_pkg::opcode_t opcode;
  logic [31:0]      imm_ext;

  // opcode and rd share bit positions in both forms
  assign opcode = inst.r_fmt.opcode;
  assign dest   = inst.r_fmt.rd;

  // immediate form, 22 bits widened to 32
  assign imm_ext = {{10{inst.i_fmt.imm[21]}}, inst.i_fmt.imm};

  always_comb begin
    result = '0;
    writes = 1'b0;
    case (opcode)
      isa_pkg::op_add: begin
        result = op_a + op_b;
        writes = 1'b1;
      end
      isa_pkg::op_sub: begin
        result = op_a - op_b;
        writes = 1'b1;
      end
      isa_pkg::op_xor: begin
        result = op_a ^ op_b;
        writes = 1'b1;
      end
      isa_pkg::op_addi: begin
        // op_b unused here, immediate takes its place
        result = op_a + imm_ext;
        writes = 1'b1;
      end
      // nop, halt and reserved codes change nothing
      default: begin
        result = '0;
        writes = 1'b0;
      end
    endcase
  end

  assign is_halt = (opcode == isa_pkg::op_halt);

endmodule

/* hdl/cpu_core.sv */
module cpu_core #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic              clk,
  input  logic              rst,
  // fetch master
  output logic              fetch_req,
  output logic [31:0]       fetch_addr,
  input  logic              fetch_done,
  input  isa_pkg::inst_t    fetch_data,
  input  logic              fetch_err,
  // writeback report
  output logic              wb_valid,
  output isa_pkg::reg_idx_t wb_reg,
  output logic [31:0]       wb_data,
  // status
  output logic              halted,
  output logic              bus_error
);

  // core phases
  // fetch waits on the master, exec is a single cycle, stop is final
  localparam logic [1:0] ph_fetch = 2'd0;
  localparam logic [1:0] ph_exec  = 2'd1;
  localparam logic [1:0] ph_stop  = 2'd2;

  logic [1:0]        phase;
  logic [31:0]       pc;
  isa_pkg::inst_t    ir;
  logic              ir_err;
  logic              bus_error_q;
  logic [31:0]       rd1;
  logic [31:0]       rd2;
  logic [31:0]       result;
  isa_pkg::reg_idx_t dest;
  logic              writes;
  logic              is_halt;
  logic              exec;
  logic              do_write;

  assign exec = (phase == ph_exec);

  // errored words and r0 targets never write back
  assign do_write = exec && !ir_err && writes && (dest != '0);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      phase       <= ph_fetch;
      pc          <= reset_pc;
      ir_err      <= 1'b0;
      bus_error_q <= 1'b0;
    end else begin
      case (phase)
        ph_fetch: begin
          // stall here until the master answers
          if (fetch_done) begin
            phase  <= ph_exec;
            ir_err <= fetch_err;
          end
        end
        ph_exec: begin
          if (ir_err) begin
            phase       <= ph_stop;
            bus_error_q <= 1'b1;
          end else if (is_halt) begin
            phase <= ph_stop;
          end else begin
            // next word, request goes up next cycle
            pc    <= pc + 32'd4;
            phase <= ph_fetch;
          end
        end
        default: phase <= ph_stop;
      endcase
    end
  end

  // instruction register, loaded with the done pulse
  always_ff @(posedge clk) begin
    if ((phase == ph_fetch) && fetch_done) begin
      ir <= fetch_data;
    end
  end

  reg_file u_reg_file (
    .clk    (clk),
    .rst    (rst),
    .rs1    (ir.r_fmt.rs1),
    .rs2    (ir.r_fmt.rs2),
    .rd1    (rd1),
    .rd2    (rd2),
    .we     (do_write),
    .wd_idx (dest),
    .wd     (result)
  );

  inst_exec u_inst_exec (
    .inst    (ir),
    .op_a    (rd1),
    .op_b    (rd2),
    .result  (result),
    .dest    (dest),
    .writes  (writes),
    .is_halt (is_halt)
  );

  // request level drops the cycle after done
  assign fetch_req  = (phase == ph_fetch);
  assign fetch_addr = pc;

  // writeback strobe mirrors the register file write
  assign wb_valid = do_write;
  assign wb_reg   = dest;
  assign wb_data  = result;

  assign halted    = (phase == ph_stop);
  assign bus_error = bus_error_q;

endmodule

/* hdl/cpu_wrapper.sv */
module cpu_wrapper #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  logic                               clk,
  input  logic                               rst,
  // M0 read address
  output logic [axi_pkg::axi_id_bits-1:0]    arid,
  output logic [axi_pkg::axi_addr_bits-1:0]  araddr,
  output logic [axi_pkg::axi_len_bits-1:0]   arlen,
  output logic [axi_pkg::axi_size_bits-1:0]  arsize,
  output logic [1:0]                         arburst,
  output logic                               arvalid,
  input  logic                               arready,
  // M0 read data
  input  logic [axi_pkg::axi_id_bits-1:0]    rid,
  input  logic [axi_pkg::axi_data_bits-1:0]  rdata,
  input  logic [1:0]                         rresp,
  input  logic                               rlast,
  input  logic                               rvalid,
  output logic                               rready,
  // writeback and status
  output logic                               wb_valid,
  output isa_pkg::reg_idx_t                  wb_reg,
  output logic [31:0]                        wb_data,
  output logic                               halted,
  output logic                               bus_error
);

  // core to fetch master
  logic           fetch_req;
  logic [31:0]    fetch_addr;
  logic           fetch_done;
  isa_pkg::inst_t fetch_data;
  logic           fetch_err;

  cpu_core #(
    .reset_pc (reset_pc)
  ) u_cpu_core (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_done (fetch_done),
    .fetch_data (fetch_data),
    .fetch_err  (fetch_err),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .halted     (halted),
    .bus_error  (bus_error)
  );

  fetch_axi_master u_fetch_axi_master (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_done (fetch_done),
    .fetch_data (fetch_data),
    .fetch_err  (fetch_err),
    .arid       (arid),
    .araddr     (araddr),
    .arlen      (arlen),
    .arsize     (arsize),
    .arburst    (arburst),
    .arvalid    (arvalid),
    .arready    (arready),
    .rid        (rid),
    .rdata      (rdata),
    .rresp      (rresp),
    .rlast      (rlast),
    .rvalid     (rvalid),
    .rready     (rready)
  );

endmodule

/* verification/axi_rom_model.sv */
module axi_rom_model #(
  parameter logic [31:0] base_addr = 32'h0
) (
  input  logic                              clk,
  input  logic                              rst,
  // per-test setup
  input  logic                              rand_en,
  input  logic                              err_en,
  input  logic [31:0]                       err_addr,
  // AR channel
  input  logic [axi_pkg::axi_addr_bits-1:0] araddr,
  input  logic                              arvalid,
  output logic                              arready,
  // R channel
  output logic [axi_pkg::axi_id_bits-1:0]   rid,
  output logic [axi_pkg::axi_data_bits-1:0] rdata,
  output logic [1:0]                        rresp,
  output logic                              rlast,
  output logic                              rvalid,
  input  logic                              rready
);

  // program image, one word per slot
  logic [31:0] mem [0:15];

  integer      seed = 32'h34db1492;
  logic        ar_rdy = 1'b0;
  logic        r_vld = 1'b0;
  logic [31:0] r_data = '0;
  logic [1:0]  r_resp = '0;
  logic        busy = 1'b0;
  int          ar_wait = -1;
  int          r_wait = 0;
  logic        ar_hs;
  logic        r_hs;
  logic        av;
  logic        rst_s;
  logic        rand_s;
  logic        err_s;
  logic [31:0] eaddr_s;
  logic [31:0] addr_s;
  logic [31:0] addr_q;
  logic [31:0] offs;

  // 0 to 3 idle cycles when random mode is on
  function automatic int pick_delay(logic rnd);
    if (!rnd) begin
      return 0;
    end
    return int'($unsigned($random(seed)) % 4);
  endfunction

  always @(posedge clk) begin
    // sample everything at the edge
    ar_hs   = arvalid && ar_rdy;
    r_hs    = r_vld && rready;
    av      = arvalid;
    addr_s  = araddr;
    rst_s   = rst;
    rand_s  = rand_en;
    err_s   = err_en;
    eaddr_s = err_addr;
    #1;
    if (rst_s) begin
      ar_rdy  = 1'b0;
      r_vld   = 1'b0;
      busy    = 1'b0;
      ar_wait = -1;
    end else begin
      // beat accepted so rvalid drops
      if (r_hs) begin
        r_vld = 1'b0;
      end
      if (ar_hs) begin
        // address taken, read latency starts
        ar_rdy = 1'b0;
        busy   = 1'b1;
        addr_q = addr_s;
        r_wait = pick_delay(rand_s);
      end else if (av && !busy && !ar_rdy) begin
        // first sight of arvalid picks the ready delay
        if (ar_wait < 0) begin
          ar_wait = pick_delay(rand_s);
        end
        if (ar_wait == 0) begin
          ar_rdy  = 1'b1;
          ar_wait = -1;
        end else begin
          ar_wait--;
        end
      end
      if (busy) begin
        if (r_wait == 0) begin
          offs   = addr_q - base_addr;
          r_data = mem[offs[5:2]];
          // the one bad address answers with slverr
          r_resp = (err_s && addr_q == eaddr_s) ? axi_pkg::axi_resp_slverr
                                                : axi_pkg::axi_resp_okay;
          r_vld  = 1'b1;
          busy   = 1'b0;
        end else begin
          r_wait--;
        end
      end
    end
  end

  assign arready = ar_rdy;
  assign rvalid  = r_vld;
  // single beat so every beat is the last
  assign rlast   = r_vld;
  assign rid     = '0;
  assign rdata   = r_data;
  assign rresp   = r_resp;

endmodule

/* verification/tb_cpu_wrapper.sv */
module tb_cpu_wrapper;

  localparam logic [31:0] reset_pc = 32'h0000_0100;
  localparam int n_tests      = 6;
  localparam int max_words    = 8;
  localparam int reset_cycles = 8;
  localparam int quiet_cycles = 20;

  logic                              clk;
  logic                              rst;
  logic                              rand_en;
  logic                              err_en;
  logic [31:0]                       err_addr;
  logic [axi_pkg::axi_id_bits-1:0]   arid;
  logic [axi_pkg::axi_addr_bits-1:0] araddr;
  logic [axi_pkg::axi_len_bits-1:0]  arlen;
  logic [axi_pkg::axi_size_bits-1:0] arsize;
  logic [1:0]                        arburst;
  logic                              arvalid;
  logic                              arready;
  logic [axi_pkg::axi_id_bits-1:0]   rid;
  logic [axi_pkg::axi_data_bits-1:0] rdata;
  logic [1:0]                        rresp;
  logic                              rlast;
  logic                              rvalid;
  logic                              rready;
  logic                              wb_valid;
  isa_pkg::reg_idx_t                 wb_reg;
  logic [31:0]                       wb_data;
  logic                              halted;
  logic                              bus_error;

  // test table, one row per program
  string       t_name     [n_tests];
  logic [31:0] t_prog     [n_tests][max_words];
  int          t_len      [n_tests];
  bit          t_rand     [n_tests];
  bit          t_err_en   [n_tests];
  logic [31:0] t_err_addr [n_tests];
  int          row;

  // ROM image of the current row and its predicted effects
  logic [31:0]       image [16];
  isa_pkg::reg_idx_t exp_reg_q [$];
  logic [31:0]       exp_data_q [$];
  string             cur_name;
  int                exp_fetches;
  bit                exp_bus_err;
  int                fetch_cnt = 0;
  int                cycle_cnt = 0;
  int                cycle_limit = 0;
  // read accepted on AR and not yet returned on R
  bit                rd_pending = 1'b0;

  cpu_wrapper #(
    .reset_pc (reset_pc)
  ) u_cpu_wrapper (
    .clk (clk), .rst (rst),
    .arid (arid), .araddr (araddr), .arlen (arlen), .arsize (arsize),
    .arburst (arburst), .arvalid (arvalid), .arready (arready),
    .rid (rid), .rdata (rdata), .rresp (rresp), .rlast (rlast),
    .rvalid (rvalid), .rready (rready),
    .wb_valid (wb_valid), .wb_reg (wb_reg), .wb_data (wb_data),
    .halted (halted), .bus_error (bus_error)
  );

  axi_rom_model #(
    .base_addr (reset_pc)
  ) u_rom (
    .clk (clk), .rst (rst),
    .rand_en (rand_en), .err_en (err_en), .err_addr (err_addr),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rid (rid), .rdata (rdata), .rresp (rresp), .rlast (rlast),
    .rvalid (rvalid), .rready (rready)
  );

  always #50 clk = ~clk;

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_wb(string name, isa_pkg::reg_idx_t exp_reg, logic [31:0] exp_data,
                          isa_pkg::reg_idx_t act_reg, logic [31:0] act_data);
    if (act_reg !== exp_reg || act_data !== exp_data) begin
      $display("FAIL %s: writeback expected r%0d=%08h, actual r%0d=%08h",
               name, exp_reg, exp_data, act_reg, act_data);
      abort_run();
    end
  endtask

  task automatic check_addr(string name, logic [axi_pkg::axi_addr_bits-1:0] exp_addr,
                            logic [axi_pkg::axi_addr_bits-1:0] act_addr);
    if (act_addr !== exp_addr) begin
      $display("FAIL %s: araddr expected %08h, actual %08h", name, exp_addr, act_addr);
      abort_run();
    end
  endtask

  // fixed AR fields are id 0 with one beat of 4 bytes in an incr burst
  task automatic check_ar_fields(string name, logic [axi_pkg::axi_id_bits-1:0] id,
                                 logic [axi_pkg::axi_len_bits-1:0] len,
                                 logic [axi_pkg::axi_size_bits-1:0] size, logic [1:0] burst);
    if (id !== 4'h0 || len !== 4'h0 || size !== 3'b010 || burst !== 2'b01) begin
      $display("FAIL %s: AR id/len/size/burst expected 0/0/2/1, actual %0d/%0d/%0d/%0d",
               name, id, len, size, burst);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic exp_halt, logic exp_err,
                            logic act_halt, logic act_err);
    if (act_halt !== exp_halt || act_err !== exp_err) begin
      $display("FAIL %s: halted/bus_error expected %b/%b, actual %b/%b",
               name, exp_halt, exp_err, act_halt, act_err);
      abort_run();
    end
  endtask

  task automatic check_count(string name, int exp_cnt, int act_cnt);
    if (act_cnt != exp_cnt) begin
      $display("FAIL %s: fetch count expected %0d, actual %0d", name, exp_cnt, act_cnt);
      abort_run();
    end
  endtask

  // instruction encoders
  // opcode 31:28, rd 27:25, rs1 24:22, rs2 21:19 or imm 21:0
  function automatic logic [31:0] enc_r(isa_pkg::opcode_t op, int rd, int rs1, int rs2);
    return {op, rd[2:0], rs1[2:0], rs2[2:0], 19'h0};
  endfunction

  function automatic logic [31:0] enc_i(isa_pkg::opcode_t op, int rd, int rs1, int imm);
    return {op, rd[2:0], rs1[2:0], imm[21:0]};
  endfunction

  task automatic new_row(string name, bit rnd, bit err, logic [31:0] eaddr);
    row++;
    t_name[row]     = name;
    t_rand[row]     = rnd;
    t_err_en[row]   = err;
    t_err_addr[row] = eaddr;
    t_len[row]      = 0;
  endtask

  task automatic push(logic [31:0] w);
    t_prog[row][t_len[row]] = w;
    t_len[row]++;
  endtask

  // r1=5 r2=-3 r3=2 r4=8 r5=10
  task automatic alu_program();
    push(enc_i(isa_pkg::op_addi, 1, 0, 5));
    push(enc_i(isa_pkg::op_addi, 2, 0, -3));
    push(enc_r(isa_pkg::op_add, 3, 1, 2));
    push(enc_r(isa_pkg::op_sub, 4, 1, 2));
    push(enc_r(isa_pkg::op_xor, 5, 3, 4));
    push(enc_r(isa_pkg::op_halt, 0, 0, 0));
  endtask

  task automatic build_table();
    row = -1;
    new_row("alu_no_delay", 1'b0, 1'b0, 32'h0);
    alu_program();
    new_row("alu_random", 1'b1, 1'b0, 32'h0);
    alu_program();
    // r0 targets write nothing and r0 reads back zero
    new_row("r0_target", 1'b0, 1'b0, 32'h0);
    push(enc_i(isa_pkg::op_addi, 1, 0, 9));
    push(enc_i(isa_pkg::op_addi, 0, 1, 100));
    push(enc_r(isa_pkg::op_add, 2, 0, 1));
    push(enc_r(isa_pkg::op_sub, 3, 0, 1));
    push(enc_r(isa_pkg::op_nop, 0, 0, 0));
    push(enc_r(isa_pkg::op_add, 0, 1, 1));
    push(enc_r(isa_pkg::op_xor, 4, 0, 3));
    push(enc_r(isa_pkg::op_halt, 0, 0, 0));
    // largest and smallest 22-bit immediates
    new_row("imm_edges", 1'b1, 1'b0, 32'h0);
    push(enc_i(isa_pkg::op_addi, 1, 0, 2097151));
    push(enc_i(isa_pkg::op_addi, 2, 0, -2097152));
    push(enc_r(isa_pkg::op_add, 3, 1, 2));
    push(enc_r(isa_pkg::op_xor, 4, 3, 1));
    push(enc_r(isa_pkg::op_sub, 5, 2, 1));
    push(enc_i(isa_pkg::op_addi, 6, 5, 1));
    push(enc_i(isa_pkg::op_addi, 7, 6, -1));
    push(enc_r(isa_pkg::op_halt, 0, 0, 0));
    // third word answers slverr
    new_row("slverr_mid", 1'b0, 1'b1, reset_pc + 32'd8);
    push(enc_i(isa_pkg::op_addi, 1, 0, 1));
    push(enc_i(isa_pkg::op_addi, 2, 1, 2));
    push(enc_r(isa_pkg::op_add, 3, 1, 2));
    push(enc_i(isa_pkg::op_addi, 4, 3, 4));
    push(enc_r(isa_pkg::op_halt, 0, 0, 0));
    new_row("slverr_first", 1'b1, 1'b1, reset_pc);
    push(enc_i(isa_pkg::op_addi, 1, 0, 3));
    push(enc_r(isa_pkg::op_halt, 0, 0, 0));
  endtask

  // ISA reference model over the ROM image
  task automatic predict(int t);
    logic [31:0]       regs [8];
    logic [31:0]       w;
    logic [31:0]       imm;
    logic [31:0]       val;
    logic [3:0]        op;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    bit                wr;
    bit                stop;
    for (int i = 0; i < 8; i++) begin
      regs[i] = '0;
    end
    exp_reg_q.delete();
    exp_data_q.delete();
    exp_fetches = 0;
    exp_bus_err = 1'b0;
    stop        = 1'b0;
    for (int i = 0; i < 16 && !stop; i++) begin
      w = image[i];
      exp_fetches++;
      if (t_err_en[t] && (reset_pc + 32'(4 * i)) == t_err_addr[t]) begin
        // errored word never executes
        exp_bus_err = 1'b1;
        stop        = 1'b1;
      end else begin
        op  = w[31:28];
        rd  = w[27:25];
        rs1 = w[24:22];
        rs2 = w[21:19];
        imm = {{10{w[21]}}, w[21:0]};
        wr  = 1'b1;
        val = '0;
        case (op)
          4'd1: val = regs[rs1] + regs[rs2];
          4'd2: val = regs[rs1] - regs[rs2];
          4'd3: val = regs[rs1] ^ regs[rs2];
          4'd8: val = regs[rs1] + imm;
          4'd15: begin
            wr   = 1'b0;
            stop = 1'b1;
          end
          default: wr = 1'b0;
        endcase
        if (wr && rd != 0) begin
          regs[rd] = val;
          exp_reg_q.push_back(rd);
          exp_data_q.push_back(val);
        end
      end
    end
  endtask

  task automatic run_test(int t);
    cur_name = t_name[t];
    // unused slots hold halt with the slot index below
    for (int i = 0; i < 16; i++) begin
      if (i < t_len[t]) begin
        image[i] = t_prog[t][i];
      end else begin
        image[i] = 32'hf000_0000 | 32'(i);
      end
      u_rom.mem[i] = image[i];
    end
    predict(t);
    @(posedge clk);
    #1;
    rst      = 1'b1;
    rand_en  = t_rand[t];
    err_en   = t_err_en[t];
    err_addr = t_err_addr[t];
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    while (!halted) begin
      @(posedge clk);
    end
    // watch for stray requests after the stop
    repeat (quiet_cycles) @(posedge clk);
    if (exp_reg_q.size() != 0) begin
      $display("%s: %0d expected writebacks never arrived", cur_name, exp_reg_q.size());
      abort_run();
    end
    check_count(cur_name, exp_fetches, fetch_cnt);
    check_flag(cur_name, 1'b1, exp_bus_err, halted, bus_error);
  endtask

  // bus and writeback monitor sampled on the rising edge
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("simulation timed out");
      abort_run();
    end
    if (rst) begin
      fetch_cnt  = 0;
      rd_pending = 1'b0;
    end else begin
      // rready belongs to the data phase of an accepted read
      if (rready && !rd_pending) begin
        $display("%s: rready was high with no read outstanding", cur_name);
        abort_run();
      end
      if (arvalid && arready) begin
        check_addr(cur_name, reset_pc + 32'(fetch_cnt * 4), araddr);
        check_ar_fields(cur_name, arid, arlen, arsize, arburst);
        fetch_cnt++;
        rd_pending = 1'b1;
      end
      if (rvalid && rready) begin
        rd_pending = 1'b0;
      end
      if (halted && arvalid) begin
        $display("%s: a read address was issued after the core halted", cur_name);
        abort_run();
      end
      if (wb_valid) begin
        if (exp_reg_q.size() == 0) begin
          $display("%s: writeback to r%0d that the program should not make", cur_name, wb_reg);
          abort_run();
        end else begin
          check_wb(cur_name, exp_reg_q.pop_front(), exp_data_q.pop_front(), wb_reg, wb_data);
        end
      end
    end
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    rand_en  = 1'b0;
    err_en   = 1'b0;
    err_addr = '0;
    build_table();
    // 12 cycles per word plus reset, slack and the quiet window
    for (int t = 0; t < n_tests; t++) begin
      cycle_limit += t_len[t] * 12 + 20 + reset_cycles + quiet_cycles;
    end
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

/* flist.f */
hdl/axi_pkg.sv
hdl/isa_pkg.sv
hdl/fetch_axi_master.sv
hdl/reg_file.sv
hdl/inst_exec.sv
hdl/cpu_core.sv
hdl/cpu_wrapper.sv
verification/axi_rom_model.sv
verification/tb_cpu_wrapper.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it to a log and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f flist.f --top-module tb_cpu_wrapper -o sim_cpu_wrapper \
  && ./obj_dir/sim_cpu_wrapper > sim.log 2>&1

[ -f sim.log ] && cat sim.log

grep -q "all tests passed" sim.log \
  && echo "simulation PASSED" \
  || { echo "simulation FAILED, see sim.log"; exit 1; }
